// ==== spindle_board.f ====
logic/spindle_pkg.sv
logic/param_regs.sv
logic/spi_rx.sv
logic/spindle_channel.sv
logic/mult_arbiter.sv
logic/spi_tx.sv
logic/spindle_board.sv
bench/spindle_board_props.sv
bench/spindle_board_tb.sv

// ==== Makefile ====
TOOL       = verilator
TOP        = spindle_board_tb
FLIST      = spindle_board.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
OBJ        = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== bench/spindle_board_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module spindle_board_tb
    import spindle_pkg::*;
();

    localparam int base_rate = 1000;
    localparam int sck_half  = 4;

    // DUT pins
    logic ep50trig;
    logic reset_global;
    logic host_trig;
    param_id_t host_addr;
    logic [lce_w-1:0] host_data;
    logic sck_r;
    logic ssel_r;
    logic data_bic_r;
    logic data_tri_r;
    wire sck_s;
    wire ssel_s;
    wire data_bic_s;
    wire data_tri_s;
    wire [lce_w-1:0] ia_bic;
    wire [lce_w-1:0] ii_bic;
    wire [lce_w-1:0] ia_tri;
    wire [lce_w-1:0] ii_tri;
    wire valid_bic;
    wire valid_tri;

    // host register mirror and model state
    logic [lce_w-1:0] gd;
    logic [lce_w-1:0] gs;
    logic [lce_w-1:0] rest;
    logic [lce_w-1:0] prev_bic;
    logic [lce_w-1:0] prev_tri;
    logic [lce_w-1:0] exp_ia_bic;
    logic [lce_w-1:0] exp_ii_bic;
    logic [lce_w-1:0] exp_ia_tri;
    logic [lce_w-1:0] exp_ii_tri;

    // serial output decoder
    logic prev_sck;
    logic prev_ssel;
    logic [lce_w-1:0] tx_bic;
    logic [lce_w-1:0] tx_tri;
    int tx_bits;
    int tx_frames;

    int checks;
    int errors;
    int timeouts;
    int prop_fails;
    integer seed;

    spindle_board #(.base_rate(base_rate), .sck_half(sck_half)) spindle_board_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .host_trig(host_trig), .host_addr(host_addr), .host_data(host_data),
        .sck_r(sck_r), .ssel_r(ssel_r), .data_bic_r(data_bic_r), .data_tri_r(data_tri_r),
        .sck_s(sck_s), .ssel_s(ssel_s), .data_bic_s(data_bic_s), .data_tri_s(data_tri_s),
        .ia_bic(ia_bic), .ii_bic(ii_bic), .ia_tri(ia_tri), .ii_tri(ii_tri),
        .valid_bic(valid_bic), .valid_tri(valid_tri)
    );

    // 40 ns period
    initial begin
        ep50trig = 1'b0;
        forever #20 ep50trig = ~ep50trig;
    end

    //////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////

    // base + (gain * diff) >>> 8, clamped to 16 bits
    function automatic logic [lce_w-1:0] model_rate(input longint gain, input longint diff);
        longint p;
        p = ((gain * diff) >>> 8) + longint'(base_rate);
        if (p < 0) begin
            return 16'h0000;
        end else if (p > 65535) begin
            return 16'hffff;
        end
        return p[lce_w-1:0];
    endfunction

    task automatic check_val(input string name, input logic [lce_w-1:0] got,
                             input logic [lce_w-1:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    // inputs change 2 ns after the edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge ep50trig);
            #2;
        end
    endtask

    task automatic host_write(input param_id_t addr, input logic [lce_w-1:0] data);
        step(1);
        host_trig = 1'b1;
        host_addr = addr;
        host_data = data;
        // keep the mirror in step with what was written
        case (addr)
            prm_gamma_dyn: gd = data;
            prm_gamma_sta: gs = data;
            prm_lce_rest:  rest = data;
            default: ;
        endcase
        step(1);
        host_trig = 1'b0;
    endtask

    // serial master, msb first, 4 clocks per sck phase
    task automatic send_frame(input logic [lce_w-1:0] lb, input logic [lce_w-1:0] lt);
        ssel_r = 1'b0;
        step(4);
        for (int i = lce_w - 1; i >= 0; i--) begin
            data_bic_r = lb[i];
            data_tri_r = lt[i];
            step(4);
            sck_r = 1'b1;
            step(4);
            sck_r = 1'b0;
        end
        step(4);
        ssel_r = 1'b1;
    endtask

    // both channels must finish, in either order
    task automatic wait_rates();
        logic seen_b;
        logic seen_t;
        int n;
        seen_b = 1'b0;
        seen_t = 1'b0;
        n = 0;
        while (!(seen_b && seen_t) && n < 600) begin
            step(1);
            seen_b = seen_b | valid_bic;
            seen_t = seen_t | valid_tri;
            n++;
        end
        if (!(seen_b && seen_t)) begin
            $display("timeout waiting for rate_valid from both channels");
            timeouts++;
        end
    endtask

    task automatic wait_tx(input int target);
        int n;
        n = 0;
        while (tx_frames < target && n < 600) begin
            step(1);
            n++;
        end
        if (tx_frames < target) begin
            $display("timeout waiting for a transmitted frame");
            timeouts++;
        end
    endtask

    // compare all four rates, then advance previous lengths
    task automatic finish_check(input logic [lce_w-1:0] lb, input logic [lce_w-1:0] lt,
                                input int target);
        wait_rates();
        check_val("ia_bic", ia_bic, exp_ia_bic);
        check_val("ii_bic", ii_bic, exp_ii_bic);
        check_val("ia_tri", ia_tri, exp_ia_tri);
        check_val("ii_tri", ii_tri, exp_ii_tri);
        prev_bic = lb;
        prev_tri = lt;
        wait_tx(target);
    endtask

    task automatic run_frame(input logic [lce_w-1:0] lb, input logic [lce_w-1:0] lt);
        int target;
        target = tx_frames + 1;
        exp_ia_bic = model_rate(gd, longint'(lb) - longint'(prev_bic));
        exp_ii_bic = model_rate(gs, longint'(lb) - longint'(rest));
        exp_ia_tri = model_rate(gd, longint'(lt) - longint'(prev_tri));
        exp_ii_tri = model_rate(gs, longint'(lt) - longint'(rest));
        send_frame(lb, lt);
        finish_check(lb, lt, target);
    endtask

    // test length goes to both muscles
    task automatic run_test(input logic [lce_w-1:0] len);
        int target;
        target = tx_frames + 1;
        exp_ia_bic = model_rate(gd, longint'(len) - longint'(prev_bic));
        exp_ii_bic = model_rate(gs, longint'(len) - longint'(rest));
        exp_ia_tri = model_rate(gd, longint'(len) - longint'(prev_tri));
        exp_ii_tri = exp_ii_bic;
        host_write(prm_test_lce, len);
        finish_check(len, len, target);
    endtask

    //////////////////////////////////////////////////
    // serial slave on the output lanes
    //////////////////////////////////////////////////

    // sampled mid-cycle, away from the DUT edge
    always @(negedge ep50trig) begin
        if (prev_ssel && !ssel_s) begin
            tx_bits = 0;
        end
        if (!ssel_s && sck_s && !prev_sck) begin
            tx_bic = {tx_bic[lce_w-2:0], data_bic_s};
            tx_tri = {tx_tri[lce_w-2:0], data_tri_s};
            tx_bits++;
        end
        if (!prev_ssel && ssel_s) begin
            check_val("tx_bits", lce_w'(tx_bits), 16'd16);
            check_val("data_bic_s", tx_bic, exp_ia_bic);
            check_val("data_tri_s", tx_tri, exp_ia_tri);
            tx_frames++;
        end
        prev_sck = sck_s;
        prev_ssel = ssel_s;
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        reset_global = 1'b1;
        host_trig = 1'b0;
        host_addr = prm_gamma_dyn;
        host_data = '0;
        sck_r = 1'b0;
        ssel_r = 1'b1;
        data_bic_r = 1'b0;
        data_tri_r = 1'b0;
        gd = gamma_dyn_rst;
        gs = gamma_sta_rst;
        rest = lce_rest_rst;
        prev_bic = '0;
        prev_tri = '0;
        exp_ia_bic = '0;
        exp_ia_tri = '0;
        prev_sck = 1'b0;
        prev_ssel = 1'b1;
        tx_bic = '0;
        tx_tri = '0;
        tx_bits = 0;
        tx_frames = 0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        seed = 32'he5a4;
        step(8);
        reset_global = 1'b0;
        step(2);

        // idle outputs after reset
        check_val("ssel_s", {15'd0, ssel_s}, 16'd1);
        check_val("sck_s", {15'd0, sck_s}, 16'd0);
        check_val("valid_bic", {15'd0, valid_bic}, 16'd0);
        check_val("valid_tri", {15'd0, valid_tri}, 16'd0);
        check_val("ia_bic", ia_bic, 16'd0);
        check_val("ii_bic", ii_bic, 16'd0);
        check_val("ia_tri", ia_tri, 16'd0);
        check_val("ii_tri", ii_tri, 16'd0);

        // reset gains, previous length 0
        run_frame(16'd17000, 16'd15500);

        // new gains and rest length
        host_write(prm_gamma_dyn, 16'd300);
        host_write(prm_gamma_sta, 16'd200);
        host_write(prm_lce_rest, 16'd20000);
        run_frame(16'd21000, 16'd19000);
        repeat (6) begin
            run_frame(lce_w'($random(seed)), lce_w'($random(seed)));
        end

        // saturation, II high then Ia low
        host_write(prm_gamma_dyn, 16'd1000);
        host_write(prm_gamma_sta, 16'hffff);
        run_frame(16'd60000, 16'd62000);
        run_frame(16'd100, 16'd300);

        // test length instead of serial input
        host_write(prm_source, 16'd1);
        run_test(16'd30000);
        run_test(16'd12345);
        host_write(prm_source, 16'd0);
        run_frame(16'd15000, 16'd25000);
        step(4);

        prop_fails = spindle_board_i.mult_arbiter_i.props_i.fail_count;
        $display("checks %0d, errors %0d, timeouts %0d, arbiter assertion failures %0d",
                 checks, errors, timeouts, prop_fails);
        if (errors == 0 && timeouts == 0 && prop_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/spindle_board_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module spindle_board_props (
    input wire       ep50trig,
    input wire       reset_global,
    input wire [1:0] req,
    input wire [1:0] gnt,
    input wire       product_valid
);

    // failed property count
    int fail_count = 0;

    // never two grants at once
    gnt_onehot: assert property (@(posedge ep50trig) disable iff (reset_global)
        $onehot0(gnt))
    else begin
        $error("multiplier grant is not zero or one-hot");
        fail_count++;
    end

    // grant only to a live request
    gnt_to_req: assert property (@(posedge ep50trig) disable iff (reset_global)
        (gnt & ~req) == 2'b00)
    else begin
        $error("multiplier grant given without a request");
        fail_count++;
    end

    // waiting requesters hold on until served
    req_hold: assert property (@(posedge ep50trig) disable iff (reset_global)
        ((req & ~gnt) != 2'b00) |=> ((req & $past(req & ~gnt)) == $past(req & ~gnt)))
    else begin
        $error("multiplier request dropped before its grant");
        fail_count++;
    end

    // registered product lags the grant by one cycle
    prod_follows: assert property (@(posedge ep50trig) disable iff (reset_global)
        product_valid == $past(|gnt))
    else begin
        $error("product_valid does not follow the grant by one cycle");
        fail_count++;
    end

endmodule

bind mult_arbiter spindle_board_props props_i (
    .ep50trig(ep50trig),
    .reset_global(reset_global),
    .req(req),
    .gnt(gnt),
    .product_valid(product_valid)
);

`default_nettype wire

// ==== logic/spindle_board.sv ====
`timescale 1ns/100ps
`default_nettype none

module spindle_board
    import spindle_pkg::*;
#(
    parameter int base_rate = 1000,
    parameter int sck_half  = 4
) (
    input  wire               ep50trig,
    input  wire               reset_global,
    input  wire               host_trig,
    input  wire param_id_t    host_addr,
    input  wire [lce_w-1:0]   host_data,
    input  wire               sck_r,
    input  wire               ssel_r,
    input  wire               data_bic_r,
    input  wire               data_tri_r,
    output wire               sck_s,
    output wire               ssel_s,
    output wire               data_bic_s,
    output wire               data_tri_s,
    output wire [lce_w-1:0]   ia_bic,
    output wire [lce_w-1:0]   ii_bic,
    output wire [lce_w-1:0]   ia_tri,
    output wire [lce_w-1:0]   ii_tri,
    output wire               valid_bic,
    output wire               valid_tri
);

    // host parameters
    wire [lce_w-1:0] gamma_dyn;
    wire [lce_w-1:0] gamma_sta;
    wire [lce_w-1:0] lce_rest;
    wire [lce_w-1:0] test_lce;
    wire use_test;
    wire test_start;

    // received lengths
    wire [lce_w-1:0] lce_bic;
    wire [lce_w-1:0] lce_tri;
    wire frame_done;

    // multiplier bus, index 0 biceps, 1 triceps
    wire req_bic;
    wire req_tri;
    wire signed [mul_a_w-1:0] a_bic;
    wire signed [mul_a_w-1:0] a_tri;
    wire [lce_w-1:0] b_bic;
    wire [lce_w-1:0] b_tri;
    wire [1:0] gnt;
    wire signed [prod_w-1:0] product;
    wire product_valid;

    param_regs param_regs_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .host_trig(host_trig), .host_addr(host_addr), .host_data(host_data),
        .gamma_dyn(gamma_dyn), .gamma_sta(gamma_sta), .lce_rest(lce_rest),
        .test_lce(test_lce), .use_test(use_test), .test_start(test_start)
    );

    spi_rx spi_rx_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .sck_r(sck_r), .ssel_r(ssel_r), .data_bic_r(data_bic_r), .data_tri_r(data_tri_r),
        .lce_bic(lce_bic), .lce_tri(lce_tri), .frame_done(frame_done)
    );

    spindle_channel #(.base_rate(base_rate)) bic_chan_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .start_spi(frame_done), .start_test(test_start),
        .lce_spi(lce_bic), .test_lce(test_lce), .use_test(use_test),
        .gamma_dyn(gamma_dyn), .gamma_sta(gamma_sta), .lce_rest(lce_rest),
        .mul_gnt(gnt[0]), .product(product), .product_valid(product_valid),
        .mul_req(req_bic), .mul_a(a_bic), .mul_b(b_bic),
        .ia_rate(ia_bic), .ii_rate(ii_bic), .rate_valid(valid_bic)
    );

    spindle_channel #(.base_rate(base_rate)) tri_chan_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .start_spi(frame_done), .start_test(test_start),
        .lce_spi(lce_tri), .test_lce(test_lce), .use_test(use_test),
        .gamma_dyn(gamma_dyn), .gamma_sta(gamma_sta), .lce_rest(lce_rest),
        .mul_gnt(gnt[1]), .product(product), .product_valid(product_valid),
        .mul_req(req_tri), .mul_a(a_tri), .mul_b(b_tri),
        .ia_rate(ia_tri), .ii_rate(ii_tri), .rate_valid(valid_tri)
    );

    mult_arbiter mult_arbiter_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .req({req_tri, req_bic}),
        .a0(a_bic), .b0(b_bic), .a1(a_tri), .b1(b_tri),
        .gnt(gnt), .product(product), .product_valid(product_valid)
    );

    // Ia rates of both muscles go back out serially
    spi_tx #(.sck_half(sck_half)) spi_tx_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .rate_bic(ia_bic), .rate_tri(ia_tri),
        .valid_bic(valid_bic), .valid_tri(valid_tri),
        .sck_s(sck_s), .ssel_s(ssel_s), .data_bic_s(data_bic_s), .data_tri_s(data_tri_s)
    );

endmodule

`default_nettype wire

// ==== logic/spi_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_tx
    import spindle_pkg::*;
#(
    parameter int sck_half = 4
) (
    input  wire               ep50trig,
    input  wire               reset_global,
    input  wire [lce_w-1:0]   rate_bic,
    input  wire [lce_w-1:0]   rate_tri,
    input  wire               valid_bic,
    input  wire               valid_tri,
    output logic              sck_s,
    output logic              ssel_s,
    output logic              data_bic_s,
    output logic              data_tri_s
);

    localparam int div_w = $clog2(sck_half + 1);

    logic got_bic;
    logic got_tri;
    logic both_seen;
    logic pend_full;
    logic busy;
    logic tick;
    logic [lce_w-1:0] pend_bic;
    logic [lce_w-1:0] pend_tri;
    logic [lce_w-1:0] shift_bic;
    logic [lce_w-1:0] shift_tri;
    logic [div_w-1:0] div_cnt;
    // 0..15 bits, 16 trailing half, 17 select-high gap
    logic [4:0] bit_cnt;

    // both muscles reported since the last latch
    assign both_seen = (got_bic | valid_bic) & (got_tri | valid_tri);
    assign tick = (div_cnt == div_w'(sck_half - 1));

    // msb first on both lanes
    assign data_bic_s = shift_bic[lce_w-1];
    assign data_tri_s = shift_tri[lce_w-1];

    //////////////////////////////////////////////////
    // valid collection and frame shifter
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            got_bic   <= 1'b0;
            got_tri   <= 1'b0;
            pend_full <= 1'b0;
            busy      <= 1'b0;
            sck_s     <= 1'b0;
            ssel_s    <= 1'b1;
            div_cnt   <= '0;
            bit_cnt   <= 5'd0;
            shift_bic <= '0;
            shift_tri <= '0;
        end else begin
            if (both_seen) begin
                got_bic <= 1'b0;
                got_tri <= 1'b0;
            end else begin
                got_bic <= got_bic | valid_bic;
                got_tri <= got_tri | valid_tri;
            end

            // pending slot, a newer pair just overwrites
            if (both_seen) begin
                pend_full <= 1'b1;
            end else if (!busy && pend_full) begin
                pend_full <= 1'b0;
            end

            if (!busy) begin
                if (pend_full) begin
                    busy      <= 1'b1;
                    ssel_s    <= 1'b0;
                    div_cnt   <= '0;
                    bit_cnt   <= 5'd0;
                    shift_bic <= pend_bic;
                    shift_tri <= pend_tri;
                end
            end else begin
                div_cnt <= tick ? '0 : div_cnt + div_w'(1);
                if (tick) begin
                    if (bit_cnt < 5'd16) begin
                        sck_s <= ~sck_s;
                        // falling edge moves to the next bit
                        if (sck_s) begin
                            bit_cnt   <= bit_cnt + 5'd1;
                            shift_bic <= {shift_bic[lce_w-2:0], 1'b0};
                            shift_tri <= {shift_tri[lce_w-2:0], 1'b0};
                        end
                    end else if (bit_cnt == 5'd16) begin
                        ssel_s  <= 1'b1;
                        bit_cnt <= 5'd17;
                    end else begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // rates are steady from their valid onward
    always_ff @(posedge ep50trig) begin
        if (both_seen) begin
            pend_bic <= rate_bic;
            pend_tri <= rate_tri;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mult_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mult_arbiter
    import spindle_pkg::*;
(
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire [1:0]                  req,
    input  wire signed [mul_a_w-1:0]   a0,
    input  wire [lce_w-1:0]            b0,
    input  wire signed [mul_a_w-1:0]   a1,
    input  wire [lce_w-1:0]            b1,
    output logic [1:0]                 gnt,
    output logic signed [prod_w-1:0]   product,
    output logic                       product_valid
);

    // index of the requester served most recently
    logic last;
    logic signed [mul_a_w-1:0] a_sel;
    logic [lce_w-1:0] b_sel;
    logic signed [prod_w-1:0] a_ext;
    logic signed [prod_w-1:0] b_ext;

    // lone requester wins, a tie goes to whoever waited
    assign gnt = (req == 2'b11) ? (last ? 2'b01 : 2'b10) : req;

    assign a_sel = gnt[1] ? a1 : a0;
    assign b_sel = gnt[1] ? b1 : b0;

    // a sign extended, b treated as unsigned
    assign a_ext = {{(prod_w - mul_a_w){a_sel[mul_a_w-1]}}, a_sel};
    assign b_ext = {{(prod_w - lce_w){1'b0}}, b_sel};

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            last          <= 1'b0;
            product_valid <= 1'b0;
        end else begin
            product_valid <= |gnt;
            if (|gnt) begin
                last <= gnt[1];
            end
        end
    end

    // product one cycle after grant
    always_ff @(posedge ep50trig) begin
        if (|gnt) begin
            product <= a_ext * b_ext;
        end
    end

endmodule

`default_nettype wire

// ==== logic/spindle_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

module spindle_channel
    import spindle_pkg::*;
#(
    parameter int base_rate = 1000
) (
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire                        start_spi,
    input  wire                        start_test,
    input  wire [lce_w-1:0]            lce_spi,
    input  wire [lce_w-1:0]            test_lce,
    input  wire                        use_test,
    input  wire [lce_w-1:0]            gamma_dyn,
    input  wire [lce_w-1:0]            gamma_sta,
    input  wire [lce_w-1:0]            lce_rest,
    input  wire                        mul_gnt,
    input  wire signed [prod_w-1:0]    product,
    input  wire                        product_valid,
    output logic                       mul_req,
    output logic signed [mul_a_w-1:0]  mul_a,
    output logic [lce_w-1:0]           mul_b,
    output logic [lce_w-1:0]           ia_rate,
    output logic [lce_w-1:0]           ii_rate,
    output logic                       rate_valid
);

    chan_state_t state;
    logic [lce_w-1:0] lce_cur;
    logic [lce_w-1:0] lce_prev;
    // granted last cycle, product due now
    logic wait_prod;
    logic own_product;
    logic signed [prod_w-1:0] prod_dyn;
    logic signed [mul_a_w-1:0] velocity;
    logic signed [mul_a_w-1:0] stretch;

    // base_rate + (p >>> 8), clamped to 0..65535
    function automatic logic [lce_w-1:0] sat_rate(input logic signed [prod_w-1:0] p);
        logic signed [prod_w-1:0] sum;
        sum = (p >>> 8) + prod_w'(base_rate);
        if (sum < 0) begin
            return '0;
        end else if (sum > 65535) begin
            return '1;
        end
        return sum[lce_w-1:0];
    endfunction

    //////////////////////////////////////////////////
    // operands for the shared multiplier
    //////////////////////////////////////////////////

    assign velocity = $signed({2'b00, lce_cur}) - $signed({2'b00, lce_prev});
    assign stretch  = $signed({2'b00, lce_cur}) - $signed({2'b00, lce_rest});

    // level request, dropped while our product is in flight
    assign mul_req = ((state == ch_mul_dyn) || (state == ch_mul_sta)) && !wait_prod;
    assign mul_a   = (state == ch_mul_sta) ? stretch : velocity;
    assign mul_b   = (state == ch_mul_sta) ? gamma_sta : gamma_dyn;

    // shared valid belongs to us only right after our grant
    assign own_product = wait_prod & product_valid;

    //////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state      <= ch_idle;
            wait_prod  <= 1'b0;
            lce_prev   <= '0;
            ia_rate    <= '0;
            ii_rate    <= '0;
            rate_valid <= 1'b0;
        end else begin
            rate_valid <= 1'b0;
            if (mul_gnt) begin
                wait_prod <= 1'b1;
            end else if (own_product) begin
                wait_prod <= 1'b0;
            end

            case (state)
                // starts while busy fall through unnoticed
                ch_idle: begin
                    if (start_spi || start_test) begin
                        state <= ch_mul_dyn;
                    end
                end
                // velocity term, wait for its product
                ch_mul_dyn: begin
                    if (own_product) begin
                        state <= ch_mul_sta;
                    end
                end
                // stretch term
                ch_mul_sta: begin
                    if (mul_gnt) begin
                        state <= ch_done;
                    end
                end
                ch_done: begin
                    if (own_product) begin
                        ia_rate    <= sat_rate(prod_dyn);
                        ii_rate    <= sat_rate(product);
                        rate_valid <= 1'b1;
                        lce_prev   <= lce_cur;
                        state      <= ch_idle;
                    end
                end
                default: state <= ch_idle;
            endcase
        end
    end

    // length latch and first product
    always_ff @(posedge ep50trig) begin
        if ((state == ch_idle) && (start_spi || start_test)) begin
            lce_cur <= use_test ? test_lce : lce_spi;
        end
        if ((state == ch_mul_dyn) && own_product) begin
            prod_dyn <= product;
        end
    end

endmodule

`default_nettype wire

// ==== logic/spi_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_rx
    import spindle_pkg::*;
(
    input  wire               ep50trig,
    input  wire               reset_global,
    input  wire               sck_r,
    input  wire               ssel_r,
    input  wire               data_bic_r,
    input  wire               data_tri_r,
    output logic [lce_w-1:0]  lce_bic,
    output logic [lce_w-1:0]  lce_tri,
    output logic              frame_done
);

    // two sync flops, third stage only for edge detect
    logic [2:0] sck_q;
    logic [2:0] ssel_q;
    logic [1:0] bic_q;
    logic [1:0] tri_q;
    // bit count, parks at 17 on overlong frames
    logic [4:0] bit_cnt;
    logic [lce_w-1:0] shift_bic;
    logic [lce_w-1:0] shift_tri;
    logic sck_rise;
    logic ssel_rise;
    logic ssel_low;

    assign sck_rise  = sck_q[1] & ~sck_q[2];
    assign ssel_rise = ssel_q[1] & ~ssel_q[2];
    assign ssel_low  = ~ssel_q[1];

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sck_q      <= 3'b000;
            ssel_q     <= 3'b111;
            bic_q      <= 2'b00;
            tri_q      <= 2'b00;
            bit_cnt    <= 5'd0;
            lce_bic    <= '0;
            lce_tri    <= '0;
            frame_done <= 1'b0;
        end else begin
            sck_q  <= {sck_q[1:0], sck_r};
            ssel_q <= {ssel_q[1:0], ssel_r};
            bic_q  <= {bic_q[0], data_bic_r};
            tri_q  <= {tri_q[0], data_tri_r};

            // count rising sck edges inside the select window
            if (!ssel_low) begin
                bit_cnt <= 5'd0;
            end else if (sck_rise && (bit_cnt != 5'd17)) begin
                bit_cnt <= bit_cnt + 5'd1;
            end

            // publish only exact 16 bit frames
            frame_done <= ssel_rise && (bit_cnt == 5'd16);
            if (ssel_rise && (bit_cnt == 5'd16)) begin
                lce_bic <= shift_bic;
                lce_tri <= shift_tri;
            end
        end
    end

    // both lanes shift together, msb first
    always_ff @(posedge ep50trig) begin
        if (ssel_low && sck_rise) begin
            shift_bic <= {shift_bic[lce_w-2:0], bic_q[1]};
            shift_tri <= {shift_tri[lce_w-2:0], tri_q[1]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/param_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module param_regs
    import spindle_pkg::*;
(
    input  wire                   ep50trig,
    input  wire                   reset_global,
    input  wire                   host_trig,
    input  wire param_id_t        host_addr,
    input  wire [lce_w-1:0]       host_data,
    output logic [lce_w-1:0]      gamma_dyn,
    output logic [lce_w-1:0]      gamma_sta,
    output logic [lce_w-1:0]      lce_rest,
    output logic [lce_w-1:0]      test_lce,
    output logic                  use_test,
    output logic                  test_start
);

    // raw source word from the host
    logic [lce_w-1:0] source_reg;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            gamma_dyn  <= gamma_dyn_rst;
            gamma_sta  <= gamma_sta_rst;
            lce_rest   <= lce_rest_rst;
            test_lce   <= test_lce_rst;
            source_reg <= source_rst;
            test_start <= 1'b0;
        end else begin
            // kick both channels one cycle after a test length lands
            test_start <= host_trig && (host_addr == prm_test_lce) && use_test;
            if (host_trig) begin
                case (host_addr)
                    prm_gamma_dyn: gamma_dyn  <= host_data;
                    prm_gamma_sta: gamma_sta  <= host_data;
                    prm_lce_rest:  lce_rest   <= host_data;
                    prm_test_lce:  test_lce   <= host_data;
                    prm_source:    source_reg <= host_data;
                    // unknown address, nothing stored
                    default: ;
                endcase
            end
        end
    end

    // any nonzero source word selects the test length
    assign use_test = (source_reg != '0);

endmodule

`default_nettype wire

// ==== logic/spindle_pkg.sv ====
`default_nettype none

package spindle_pkg;

    // width of a muscle length and of a firing rate
    localparam int lce_w = 16;

    // multiplier operand a (signed) and product widths
    localparam int mul_a_w = 18;
    localparam int prod_w  = 34;

    // host register addresses
    typedef enum logic [3:0] {
        prm_gamma_dyn = 4'd0,
        prm_gamma_sta = 4'd1,
        prm_lce_rest  = 4'd2,
        prm_test_lce  = 4'd3,
        // zero picks serial lengths, nonzero picks test length
        prm_source    = 4'd4
    } param_id_t;

    // per-muscle channel sequence
    typedef enum logic [1:0] {
        ch_idle,
        ch_mul_dyn,
        ch_mul_sta,
        ch_done
    } chan_state_t;

    // register values after reset
    localparam logic [lce_w-1:0] gamma_dyn_rst = 16'd80;
    localparam logic [lce_w-1:0] gamma_sta_rst = 16'd80;
    localparam logic [lce_w-1:0] lce_rest_rst  = 16'd16384;
    localparam logic [lce_w-1:0] test_lce_rst  = 16'd0;
    localparam logic [lce_w-1:0] source_rst    = 16'd0;

endpackage

`default_nettype wire
